//--- files.f
verilog/motion_pkg.sv
verilog/objbus_pkg.sv
verilog/frame_timer.sv
verilog/jump_control.sv
verilog/drift_control.sv
verilog/bus_arbiter.sv
verilog/object_ram.sv
verilog/ball_physics_top.sv
verification/ball_physics_assertions.sv
verification/tb_ball_physics.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_ball_physics
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_ball_physics)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

//--- verification/tb_ball_physics.sv
`timescale 1ns/1ps

module tb_ball_physics;

	localparam int FRAME = 16;
	localparam int MAX_ROWS = 512;

	logic clkdiv;
	logic Reset;
	logic jump;
	logic move_left;
	logic move_right;
	logic [objbus_pkg::COORD_W-1:0] ball_x;
	logic [objbus_pkg::COORD_W-1:0] ball_y;
	logic airborne;

	// one row per frame, stimulus and expected result.
	logic stim_jump [MAX_ROWS];
	logic stim_left [MAX_ROWS];
	logic stim_right [MAX_ROWS];
	logic [9:0] exp_x [MAX_ROWS];
	logic [9:0] exp_y [MAX_ROWS];
	logic exp_air [MAX_ROWS];
	int num_rows = 0;
	bit table_ready = 1'b0;

	// velocity per jump step, negative is up.
	int velocity_table [36] = '{-12, -12, -9, -9, -9, -9, -6, -6, -6, -6, -3, -3, -3, -3,
		0, 0, 3, 3, 3, 3, 6, 6, 6, 6, 9, 9, 9, 9, 12, 12, 0, 0, 0, 0, 0, 0};

	int model_x = 320;
	int model_y = 479;
	int model_step = 0;
	bit model_air = 1'b0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0;
	integer seed = 36;
	integer rnd;

	ball_physics_top #(.FRAME_CYCLES(FRAME)) uut (
		.clkdiv(clkdiv), .Reset(Reset), .jump(jump), .move_left(move_left),
		.move_right(move_right), .ball_x(ball_x), .ball_y(ball_y), .airborne(airborne)
	);

	initial
	begin
		clkdiv = 1'b0;
		forever #4 clkdiv = ~clkdiv;
	end

	// game rules for one frame.
	task automatic apply_frame(input logic j, input logic l, input logic r);
		bit start;
		start = j && !model_air;
		if (model_air || start)
		begin
			model_y = model_y + velocity_table[model_step];
			if (model_y < 0)
				model_y = 0;
			if (model_y > 479)
				model_y = 479;
			model_air = (model_step != 35); // last step lands.
			model_step = model_air ? model_step + 1 : 0;
		end
		if (l && !r)
			model_x = (model_x < 4) ? 0 : model_x - 4;
		else if (r && !l)
			model_x = (model_x + 4 > 639) ? 639 : model_x + 4;
	endtask

	task automatic add_rows(input int count, input logic j, input logic l, input logic r);
		for (int k = 0; k < count; k++)
		begin
			stim_jump[num_rows] = j;
			stim_left[num_rows] = l;
			stim_right[num_rows] = r;
			apply_frame(j, l, r);
			exp_x[num_rows] = 10'(model_x);
			exp_y[num_rows] = 10'(model_y);
			exp_air[num_rows] = model_air;
			num_rows++;
		end
	endtask

	task automatic check_row(input int i);
		checks++;
		if (ball_x !== exp_x[i])
		begin
			$display("ERROR at %0t: row %0d ball_x %0d, expected %0d", $time, i, ball_x, exp_x[i]);
			errors++;
		end
		if (ball_y !== exp_y[i])
		begin
			$display("ERROR at %0t: row %0d ball_y %0d, expected %0d", $time, i, ball_y, exp_y[i]);
			errors++;
		end
		if (airborne !== exp_air[i])
		begin
			$display("ERROR at %0t: row %0d airborne %b, expected %b", $time, i, airborne,
				exp_air[i]);
			errors++;
		end
	endtask

	initial
	begin
		Reset <= 1'b1;
		jump <= 1'b0;
		move_left <= 1'b0;
		move_right <= 1'b0;
		add_rows(2, 1'b0, 1'b0, 1'b0);
		add_rows(1, 1'b1, 1'b0, 1'b0); // launch from rest.
		add_rows(9, 1'b0, 1'b0, 1'b0);
		add_rows(1, 1'b1, 1'b0, 1'b0); // already airborne.
		add_rows(28, 1'b0, 1'b0, 1'b0);
		add_rows(82, 1'b0, 1'b1, 1'b0); // into the left edge.
		add_rows(2, 1'b0, 1'b1, 1'b1);
		add_rows(162, 1'b0, 1'b0, 1'b1); // into the right edge.
		add_rows(1, 1'b1, 1'b1, 1'b0); // both peers on the bus.
		add_rows(39, 1'b0, 1'b1, 1'b0);
		for (int k = 0; k < 40; k++)
		begin
			rnd = $random(seed);
			add_rows(1, rnd[0], rnd[1], rnd[2]);
		end
		limit = num_rows * FRAME * 2;
		table_ready = 1'b1;

		repeat (4) @(posedge clkdiv);
		Reset <= 1'b0;
		@(negedge clkdiv);
		checks++;
		if (ball_x !== 10'd320 || ball_y !== 10'd479 || airborne !== 1'b0)
		begin
			$display("ERROR at %0t: after reset x %0d y %0d airborne %b", $time, ball_x, ball_y,
				airborne);
			errors++;
		end

		for (int i = 0; i < num_rows; i++)
		begin
			@(posedge clkdiv);
			jump <= stim_jump[i];
			move_left <= stim_left[i];
			move_right <= stim_right[i];
			@(posedge clkdiv);
			jump <= 1'b0; // one clock pulse.
			do
				@(negedge clkdiv);
			while (!uut.frame_tick);
			repeat (12) @(posedge clkdiv);
			@(negedge clkdiv);
			check_row(i);
		end

		errors = errors + uut.u_arb.u_arb_checks.failures + uut.u_ram.u_ram_checks.failures;
		$display("%0d errors in %0d checks over %0d frames", errors, checks, num_rows);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		wait (table_ready);
		while (cycles < limit)
		begin
			@(posedge clkdiv);
			cycles++;
		end
		$display("timeout: the run did not end within %0d clock cycles", limit);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- verification/ball_physics_assertions.sv
`timescale 1ns/1ps

module ball_physics_assertions #(
	parameter bit BUS_CHECKS = 1'b1
) (
	input logic clkdiv,
	input logic Reset,
	input logic jump_gnt,
	input logic drift_gnt,
	input logic jump_we,
	input logic drift_we,
	input logic [objbus_pkg::COORD_W-1:0] ball_y
);

	int failures = 0; // failed assertion count.

	generate
		if (BUS_CHECKS)
		begin : g_bus
			one_grant: assert property (@(posedge clkdiv) disable iff (Reset)
				!(jump_gnt && drift_gnt))
				else
				begin
					failures++;
					$error("both bus grants high together");
				end
			write_granted: assert property (@(posedge clkdiv) disable iff (Reset)
				(!jump_we || jump_gnt) && (!drift_we || drift_gnt))
				else
				begin
					failures++;
					$error("peer write without its grant");
				end
		end
		else
		begin : g_ram
			y_on_screen: assert property (@(posedge clkdiv) disable iff (Reset)
				ball_y <= motion_pkg::Y_FLOOR)
				else
				begin
					failures++;
					$error("ball_y below the floor row");
				end
		end
	endgenerate

endmodule

bind bus_arbiter ball_physics_assertions #(.BUS_CHECKS(1'b1)) u_arb_checks (
	.clkdiv(clkdiv), .Reset(Reset), .jump_gnt(jump_gnt), .drift_gnt(drift_gnt),
	.jump_we(jump_we), .drift_we(drift_we), .ball_y('0)
);

bind object_ram ball_physics_assertions #(.BUS_CHECKS(1'b0)) u_ram_checks (
	.clkdiv(clkdiv), .Reset(Reset), .jump_gnt(1'b0), .drift_gnt(1'b0),
	.jump_we(1'b0), .drift_we(1'b0), .ball_y(ball_y)
);

//--- verilog/ball_physics_top.sv
`timescale 1ns/1ps

module ball_physics_top #(
	parameter int FRAME_CYCLES = 16,
	parameter logic [objbus_pkg::COORD_W-1:0] DRIFT_SPEED = 4,
	parameter logic [objbus_pkg::COORD_W-1:0] X_START = 320,
	parameter logic [objbus_pkg::COORD_W-1:0] Y_START = 479
) (
	input logic clkdiv,
	input logic Reset,
	input logic jump,
	input logic move_left,
	input logic move_right,
	output logic [objbus_pkg::COORD_W-1:0] ball_x,
	output logic [objbus_pkg::COORD_W-1:0] ball_y,
	output logic airborne
);

	logic frame_tick;
	logic jump_req;
	logic jump_gnt;
	logic [objbus_pkg::ADDR_W-1:0] jump_addr;
	logic jump_we;
	logic [objbus_pkg::COORD_W-1:0] jump_wdata;
	logic drift_req;
	logic drift_gnt;
	logic [objbus_pkg::ADDR_W-1:0] drift_addr;
	logic drift_we;
	logic [objbus_pkg::COORD_W-1:0] drift_wdata;
	logic [objbus_pkg::ADDR_W-1:0] bus_addr;
	logic bus_we;
	logic [objbus_pkg::COORD_W-1:0] bus_wdata;
	logic [objbus_pkg::COORD_W-1:0] bus_rdata;

	frame_timer #(.FRAME_CYCLES(FRAME_CYCLES)) u_timer (
		.clkdiv(clkdiv), .Reset(Reset), .frame_tick(frame_tick)
	);

	jump_control u_jump (
		.clkdiv(clkdiv), .Reset(Reset), .frame_tick(frame_tick), .jump(jump),
		.jump_gnt(jump_gnt), .bus_rdata(bus_rdata), .jump_req(jump_req),
		.jump_addr(jump_addr), .jump_we(jump_we), .jump_wdata(jump_wdata),
		.airborne(airborne)
	);

	drift_control #(.DRIFT_SPEED(DRIFT_SPEED)) u_drift (
		.clkdiv(clkdiv), .Reset(Reset), .frame_tick(frame_tick),
		.move_left(move_left), .move_right(move_right), .drift_gnt(drift_gnt),
		.bus_rdata(bus_rdata), .drift_req(drift_req), .drift_addr(drift_addr),
		.drift_we(drift_we), .drift_wdata(drift_wdata)
	);

	bus_arbiter u_arb (
		.clkdiv(clkdiv), .Reset(Reset), .jump_req(jump_req), .drift_req(drift_req),
		.jump_addr(jump_addr), .jump_we(jump_we), .jump_wdata(jump_wdata),
		.drift_addr(drift_addr), .drift_we(drift_we), .drift_wdata(drift_wdata),
		.jump_gnt(jump_gnt), .drift_gnt(drift_gnt), .bus_addr(bus_addr),
		.bus_we(bus_we), .bus_wdata(bus_wdata)
	);

	object_ram #(.X_START(X_START), .Y_START(Y_START)) u_ram (
		.clkdiv(clkdiv), .Reset(Reset), .bus_addr(bus_addr), .bus_we(bus_we),
		.bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .ball_x(ball_x),
		.ball_y(ball_y)
	);

endmodule

//--- verilog/object_ram.sv
`timescale 1ns/1ps

module object_ram #(
	parameter logic [objbus_pkg::COORD_W-1:0] X_START = 320,
	parameter logic [objbus_pkg::COORD_W-1:0] Y_START = 479
) (
	input logic clkdiv,
	input logic Reset,
	input logic [objbus_pkg::ADDR_W-1:0] bus_addr,
	input logic bus_we,
	input logic [objbus_pkg::COORD_W-1:0] bus_wdata,
	output logic [objbus_pkg::COORD_W-1:0] bus_rdata,
	output logic [objbus_pkg::COORD_W-1:0] ball_x,
	output logic [objbus_pkg::COORD_W-1:0] ball_y
);

	logic [objbus_pkg::COORD_W-1:0] mem [2];

	always_ff @(posedge clkdiv or posedge Reset)
	begin
		if (Reset)
		begin
			mem[objbus_pkg::ADDR_X] <= X_START;
			mem[objbus_pkg::ADDR_Y] <= Y_START;
		end
		else if (bus_we)
			mem[bus_addr] <= bus_wdata;
	end

	always_ff @(posedge clkdiv)
	begin
		bus_rdata <= mem[bus_addr]; // one cycle read latency.
	end

	assign ball_x = mem[objbus_pkg::ADDR_X];
	assign ball_y = mem[objbus_pkg::ADDR_Y];

endmodule

//--- verilog/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input logic clkdiv,
	input logic Reset,
	input logic jump_req,
	input logic drift_req,
	input logic [objbus_pkg::ADDR_W-1:0] jump_addr,
	input logic jump_we,
	input logic [objbus_pkg::COORD_W-1:0] jump_wdata,
	input logic [objbus_pkg::ADDR_W-1:0] drift_addr,
	input logic drift_we,
	input logic [objbus_pkg::COORD_W-1:0] drift_wdata,
	output logic jump_gnt,
	output logic drift_gnt,
	output logic [objbus_pkg::ADDR_W-1:0] bus_addr,
	output logic bus_we,
	output logic [objbus_pkg::COORD_W-1:0] bus_wdata
);

	logic last_jump; // jump won the previous grant.

	always_ff @(posedge clkdiv or posedge Reset)
	begin
		if (Reset)
		begin
			jump_gnt <= 1'b0;
			drift_gnt <= 1'b0;
			last_jump <= 1'b0;
		end
		else if (jump_gnt || drift_gnt)
		begin
			// release on the write cycle or when the request is gone.
			if (bus_we || (jump_gnt && !jump_req) || (drift_gnt && !drift_req))
			begin
				jump_gnt <= 1'b0;
				drift_gnt <= 1'b0;
			end
		end
		else if (jump_req && (!drift_req || !last_jump))
		begin
			jump_gnt <= 1'b1;
			last_jump <= 1'b1;
		end
		else if (drift_req)
		begin
			drift_gnt <= 1'b1;
			last_jump <= 1'b0;
		end
	end

	assign bus_addr = drift_gnt ? drift_addr : jump_addr;
	assign bus_wdata = drift_gnt ? drift_wdata : jump_wdata;
	assign bus_we = (jump_gnt & jump_we) | (drift_gnt & drift_we);

endmodule

//--- verilog/drift_control.sv
`timescale 1ns/1ps

module drift_control #(
	parameter logic [objbus_pkg::COORD_W-1:0] DRIFT_SPEED = 4
) (
	input logic clkdiv,
	input logic Reset,
	input logic frame_tick,
	input logic move_left,
	input logic move_right,
	input logic drift_gnt,
	input logic [objbus_pkg::COORD_W-1:0] bus_rdata,
	output logic drift_req,
	output logic [objbus_pkg::ADDR_W-1:0] drift_addr,
	output logic drift_we,
	output logic [objbus_pkg::COORD_W-1:0] drift_wdata
);

	localparam logic [1:0] BUS_IDLE = 2'd0;
	localparam logic [1:0] BUS_REQ = 2'd1;
	localparam logic [1:0] BUS_WR = 2'd2;

	logic [1:0] bus_state;
	logic dir_left;
	logic [objbus_pkg::COORD_W:0] x_sum;

	always_ff @(posedge clkdiv or posedge Reset)
	begin
		if (Reset)
			bus_state <= BUS_IDLE;
		else if (frame_tick && (move_left ^ move_right))
			bus_state <= BUS_REQ; // both held means no motion.
		else if (bus_state == BUS_REQ && drift_gnt)
			bus_state <= BUS_WR;
		else if (bus_state == BUS_WR)
			bus_state <= BUS_IDLE;
	end

	always_ff @(posedge clkdiv)
	begin
		if (frame_tick)
			dir_left <= move_left;
	end

	always_comb
	begin
		x_sum = {1'b0, bus_rdata} + {1'b0, DRIFT_SPEED};
		if (dir_left)
			drift_wdata = (bus_rdata < DRIFT_SPEED) ? '0 : bus_rdata - DRIFT_SPEED;
		else if (x_sum > {1'b0, motion_pkg::X_MAX})
			drift_wdata = motion_pkg::X_MAX; // right edge.
		else
			drift_wdata = x_sum[objbus_pkg::COORD_W-1:0];
	end

	assign drift_req = (bus_state != BUS_IDLE);
	assign drift_we = (bus_state == BUS_WR);
	assign drift_addr = objbus_pkg::ADDR_X;

endmodule

//--- verilog/jump_control.sv
`timescale 1ns/1ps

module jump_control (
	input logic clkdiv,
	input logic Reset,
	input logic frame_tick,
	input logic jump,
	input logic jump_gnt,
	input logic [objbus_pkg::COORD_W-1:0] bus_rdata,
	output logic jump_req,
	output logic [objbus_pkg::ADDR_W-1:0] jump_addr,
	output logic jump_we,
	output logic [objbus_pkg::COORD_W-1:0] jump_wdata,
	output logic airborne
);

	localparam logic [1:0] BUS_IDLE = 2'd0;
	localparam logic [1:0] BUS_REQ = 2'd1;
	localparam logic [1:0] BUS_WR = 2'd2;

	logic [1:0] bus_state;
	logic [motion_pkg::STEP_W-1:0] step;
	logic [motion_pkg::STEP_W-1:0] cur_step;
	logic signed [motion_pkg::VEL_W-1:0] tick_vel;
	logic signed [motion_pkg::VEL_W-1:0] vel;
	logic jump_q;
	logic jump_pend;
	logic jump_rise;
	logic start;
	logic [objbus_pkg::COORD_W+1:0] y_sum;

	assign jump_rise = jump & ~jump_q;
	assign start = ~airborne & (jump_pend | jump_rise);
	assign cur_step = airborne ? step : '0;
	assign tick_vel = motion_pkg::jump_velocity(cur_step);

	always_ff @(posedge clkdiv or posedge Reset)
	begin
		if (Reset)
		begin
			jump_q <= 1'b0;
			jump_pend <= 1'b0;
			airborne <= 1'b0;
			step <= '0;
			bus_state <= BUS_IDLE;
		end
		else
		begin
			jump_q <= jump;
			if (frame_tick)
				jump_pend <= 1'b0;
			else if (jump_rise && !airborne)
				jump_pend <= 1'b1; // hold it until the next frame.
			if (frame_tick && (airborne || start))
			begin
				if (cur_step == motion_pkg::JUMP_STEPS - 1'b1)
				begin
					airborne <= 1'b0;
					step <= '0;
				end
				else
				begin
					airborne <= 1'b1;
					step <= cur_step + 1'b1;
				end
				if (tick_vel != '0)
					bus_state <= BUS_REQ;
			end
			else if (bus_state == BUS_REQ && jump_gnt)
				bus_state <= BUS_WR; // read issued this cycle.
			else if (bus_state == BUS_WR)
				bus_state <= BUS_IDLE;
		end
	end

	always_ff @(posedge clkdiv)
	begin
		if (frame_tick)
			vel <= tick_vel;
	end

	// signed sum, then clamp to the screen rows.
	always_comb
	begin
		y_sum = {2'b00, bus_rdata} + {{2{vel[motion_pkg::VEL_W-1]}}, vel};
		if (y_sum[objbus_pkg::COORD_W+1])
			jump_wdata = '0;
		else if (y_sum > {2'b00, motion_pkg::Y_FLOOR})
			jump_wdata = motion_pkg::Y_FLOOR;
		else
			jump_wdata = y_sum[objbus_pkg::COORD_W-1:0];
	end

	assign jump_req = (bus_state != BUS_IDLE);
	assign jump_we = (bus_state == BUS_WR);
	assign jump_addr = objbus_pkg::ADDR_Y;

endmodule

//--- verilog/frame_timer.sv
`timescale 1ns/1ps

module frame_timer #(
	parameter int FRAME_CYCLES = 16
) (
	input logic clkdiv,
	input logic Reset,
	output logic frame_tick
);

	localparam int CNT_W = $clog2(FRAME_CYCLES);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(FRAME_CYCLES - 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clkdiv or posedge Reset)
	begin
		if (Reset)
		begin
			count <= '0;
			frame_tick <= 1'b0;
		end
		else
		begin
			frame_tick <= (count == LAST); // one pulse per wrap.
			if (count == LAST)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

endmodule

//--- verilog/objbus_pkg.sv
package objbus_pkg;

	localparam int COORD_W = 10;
	localparam int ADDR_W = 1;

	localparam logic [ADDR_W-1:0] ADDR_Y = 1'b0;
	localparam logic [ADDR_W-1:0] ADDR_X = 1'b1;

endpackage

//--- verilog/motion_pkg.sv
package motion_pkg;

	localparam int VEL_W = 10;
	localparam int STEP_W = 6;

	localparam logic [9:0] X_MAX = 10'd639; // rightmost column.
	localparam logic [9:0] Y_FLOOR = 10'd479; // lowest row.

	localparam logic [STEP_W-1:0] JUMP_STEPS = 6'd36;

	// vertical speed for one step of the jump, negative is up.
	function automatic logic signed [VEL_W-1:0] jump_velocity(input logic [STEP_W-1:0] step);
		logic signed [VEL_W-1:0] vel;
		if (step <= 6'd1)
			vel = -10'sd12;
		else if (step <= 6'd5)
			vel = -10'sd9;
		else if (step <= 6'd9)
			vel = -10'sd6;
		else if (step <= 6'd13)
			vel = -10'sd3;
		else if (step <= 6'd15)
			vel = 10'sd0; // apex.
		else if (step <= 6'd19)
			vel = 10'sd3;
		else if (step <= 6'd23)
			vel = 10'sd6;
		else if (step <= 6'd27)
			vel = 10'sd9;
		else if (step <= 6'd29)
			vel = 10'sd12;
		else
			vel = 10'sd0; // landed, tail of the profile.
		return vel;
	endfunction

endpackage
